// File: dram_xfer.f
design/dram_xfer_pkg.sv
design/xfer_decode.sv
design/page_sequencer.sv
design/block_mover.sv
design/xfer_result.sv
design/dram_xfer_top.sv
dv/dram_xfer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the dram_xfer testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log_file=sim.log

verilator --binary --timing -f dram_xfer.f --top-module dram_xfer_tb \
  -Mdir "$obj_dir" -o dram_xfer_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$obj_dir/dram_xfer_sim" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
fi

# the log decides the result
if grep -q "^NO ERRORS$" "$log_file"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

// File: dv/dram_xfer_tb.sv
`timescale 1ns/1ps

module dram_xfer_tb;

  logic                             CLK = 1'b0;
  logic                             RST;
  logic                             cmd_valid;
  dram_xfer_pkg::xfer_cmd_t         cmd;
  logic                             busy;
  logic [dram_xfer_pkg::page_w-1:0] mcu_page_addr;
  logic                             mcu_request_align;
  logic                             mcu_grant_align = 1'b0;
  logic                             word_valid;
  logic [dram_xfer_pkg::addr_w-1:0] word_addr;
  logic [1:0]                       word_section;
  logic                             done_valid;
  dram_xfer_pkg::xfer_done_t        done;

  logic [31:0]               word_q[$];   // addresses seen on word_valid
  logic [19:0]               page_q[$];   // page address at each request rise
  int                        rise_idx[$]; // words already seen at each request rise
  logic [19:0]               exp_pages[$];
  int                        exp_counts[$];
  dram_xfer_pkg::xfer_done_t done_q;
  int                        done_cnt = 0;
  logic [1:0]                cur_section = 2'd0;
  logic                      req_prev;
  int                        grant_delay = 0;
  int                        grant_wait = 0;
  int                        cycles = 0;
  int                        limit = 0;
  logic [31:0]               lcg_state = 32'hab7;

  dram_xfer_top dut (
    .CLK               (CLK),
    .RST               (RST),
    .cmd_valid         (cmd_valid),
    .cmd               (cmd),
    .busy              (busy),
    .mcu_page_addr     (mcu_page_addr),
    .mcu_request_align (mcu_request_align),
    .mcu_grant_align   (mcu_grant_align),
    .word_valid        (word_valid),
    .word_addr         (word_addr),
    .word_section      (word_section),
    .done_valid        (done_valid),
    .done              (done)
  );

  always #10 CLK = ~CLK;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // expected page and word count of every segment
  function automatic int expect_segments(input logic [31:0] start, input logic [15:0] len);
    logic [31:0] addr;
    int          left;
    int          room;
    int          n;
    int          segs;
    exp_pages.delete();
    exp_counts.delete();
    addr = start;
    left = int'(len);
    segs = 0;
    while (left > 0)
    begin
      room = 4096 - int'(addr[11:0]);
      n = left;
      if (n > int'(dram_xfer_pkg::block_len))
        n = int'(dram_xfer_pkg::block_len);
      if (n > room)
        n = room;
      exp_pages.push_back(addr[31:12]);
      exp_counts.push_back(n);
      addr = addr + 32'(n);
      left = left - n;
      segs++;
    end
    return segs;
  endfunction

  function automatic int budget(input logic [31:0] start, input logic [15:0] len);
    return 8 * int'(len) + 40 * expect_segments(start, len) + 500;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("ERR %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  // memory controller model granting after grant_delay request cycles
  always @(negedge CLK)
  begin
    if (!RST || !mcu_request_align)
    begin
      grant_wait = 0;
      mcu_grant_align = 1'b0;
    end
    else if (grant_wait >= grant_delay)
      mcu_grant_align = 1'b1;
    else
      grant_wait++;
  end

  always @(posedge CLK)
  begin
    req_prev <= mcu_request_align;
    if (RST)
    begin
      if (word_valid)
      begin
        word_q.push_back(word_addr);
        check_val("word_section", 64'(word_section), 64'(cur_section));
        check_val("mcu_grant_align", 64'(mcu_grant_align), 64'(1));  // no word before grant
      end
      if (mcu_request_align && !req_prev)
      begin
        page_q.push_back(mcu_page_addr);
        rise_idx.push_back(word_q.size());
      end
      if (done_valid)
      begin
        done_cnt++;
        done_q = done;
      end
    end
  end

  always @(posedge CLK)
  begin
    cycles++;
    if (cycles > limit)
    begin
      $display("timeout after %0d cycles, the transfers never completed", cycles);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  end

  task automatic clear_capture(input logic [1:0] section, input int delay);
    word_q.delete();
    page_q.delete();
    rise_idx.delete();
    done_cnt    = 0;
    cur_section = section;
    grant_delay = delay;
  endtask

  task automatic send_cmd(input logic [31:0] start, input logic [15:0] len,
                          input logic [1:0] section);
    @(negedge CLK);
    cmd_valid   = 1'b1;
    cmd.start   = start;
    cmd.len     = len;
    cmd.section = section;
    @(negedge CLK);
    cmd_valid = 1'b0;
  endtask

  task automatic wait_done();
    wait (done_cnt != 0);
    repeat (4) @(negedge CLK);  // room for a stray strobe
    check_val("busy", 64'(busy), 64'(0));
  endtask

  task automatic check_xfer(input logic [31:0] start, input logic [15:0] len);
    int segs;
    int seg_end;
    segs = expect_segments(start, len);
    check_val("done_valid count", 64'(done_cnt), 64'(1));
    check_val("done.total", 64'(done_q.total), 64'(len));
    check_val("done.next_addr", 64'(done_q.next_addr), 64'(start + 32'(len)));
    check_val("word count", 64'(word_q.size()), 64'(len));
    for (int i = 0; i < word_q.size(); i++)
      check_val($sformatf("word_addr[%0d]", i), 64'(word_q[i]), 64'(start + 32'(i)));
    check_val("request rises", 64'(page_q.size()), 64'(segs));
    for (int i = 0; i < page_q.size(); i++)
    begin
      seg_end = (i + 1 < page_q.size()) ? rise_idx[i + 1] : word_q.size();
      check_val($sformatf("mcu_page_addr[%0d]", i), 64'(page_q[i]), 64'(exp_pages[i]));
      check_val($sformatf("segment words[%0d]", i), 64'(seg_end - rise_idx[i]),
                64'(exp_counts[i]));
    end
  endtask

  task automatic test_single_page(input logic [31:0] start);
    check_val("busy", 64'(busy), 64'(0));
    check_val("mcu_request_align", 64'(mcu_request_align), 64'(0));
    check_val("word_valid", 64'(word_valid), 64'(0));
    check_val("done_valid", 64'(done_valid), 64'(0));
    clear_capture(2'd1, 0);
    send_cmd(start, 16'd10, 2'd1);
    wait_done();
    check_xfer(start, 16'd10);
  endtask

  task automatic test_page_cross(input logic [31:0] start);
    clear_capture(2'd2, 1);
    send_cmd(start, 16'd30, 2'd2);
    wait_done();
    check_xfer(start, 16'd30);  // 7 then 23 words
  endtask

  task automatic test_block_split(input logic [31:0] start);
    clear_capture(2'd3, 0);
    send_cmd(start, 16'd100, 2'd3);
    wait_done();
    check_xfer(start, 16'd100);
    check_val("segments of 100 words", 64'(page_q.size()), 64'(5));
  endtask

  task automatic test_grant_delay(input logic [31:0] start, input int delay);
    clear_capture(2'd0, delay);
    send_cmd(start, 16'd40, 2'd0);
    wait_done();
    check_xfer(start, 16'd40);
  endtask

  task automatic test_busy_ignore(input logic [31:0] start);
    clear_capture(2'd1, 2);
    send_cmd(start, 16'd20, 2'd1);
    check_val("busy", 64'(busy), 64'(1));
    send_cmd(start + 32'h100, 16'd8, 2'd2);  // must be dropped
    wait_done();
    check_xfer(start, 16'd20);
  endtask

  task automatic test_zero_len(input logic [31:0] start);
    clear_capture(2'd2, 0);
    send_cmd(start, 16'd0, 2'd2);
    wait_done();
    check_xfer(start, 16'd0);
  endtask

  initial
  begin
    logic [31:0] s1;
    logic [31:0] s2;
    logic [31:0] s3;
    logic [31:0] s4;
    logic [31:0] s5;
    logic [31:0] s6;
    logic [31:0] p;
    int          d4;
    RST       = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;

    s1 = (lcg_next() & 32'hffff_f000) | ((lcg_next() >> 8) % 32'd4000);
    p  = lcg_next() >> 12;
    s2 = {p[19:0], 12'd4089};  // 7 words before the page end
    s3 = lcg_next() & 32'hffff_f000;
    s4 = lcg_next();
    d4 = 3 + int'((lcg_next() >> 16) % 32'd12);
    s5 = lcg_next();
    s6 = lcg_next();
    limit = budget(s1, 16'd10) + budget(s2, 16'd30) + budget(s3, 16'd100) +
            budget(s4, 16'd40) + budget(s5, 16'd20) + budget(s6, 16'd0);

    repeat (4) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b1;
    @(negedge CLK);

    test_single_page(s1);
    test_page_cross(s2);
    test_block_split(s3);
    test_grant_delay(s4, d4);
    test_busy_ignore(s5);
    test_zero_len(s6);

    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: design/dram_xfer_top.sv
`timescale 1ns/1ps

module dram_xfer_top (
  input  logic                             CLK,
  input  logic                             RST,
  input  logic                             cmd_valid,
  input  dram_xfer_pkg::xfer_cmd_t         cmd,
  output logic                             busy,
  output logic [dram_xfer_pkg::page_w-1:0] mcu_page_addr,
  output logic                             mcu_request_align,
  input  logic                             mcu_grant_align,
  output logic                             word_valid,
  output logic [dram_xfer_pkg::addr_w-1:0] word_addr,
  output logic [1:0]                       word_section,
  output logic                             done_valid,
  output dram_xfer_pkg::xfer_done_t        done
);

  logic                             seg_valid;
  dram_xfer_pkg::seg_t              seg;
  logic                             rpt_valid;
  dram_xfer_pkg::seg_rpt_t          rpt;

  // sequencer to mover
  logic [dram_xfer_pkg::addr_w-1:0] blck_start;
  logic [dram_xfer_pkg::cnt_w-1:0]  blck_count_req;
  logic [1:0]                       blck_section;
  logic                             blck_issue;
  logic                             blck_working;
  logic [dram_xfer_pkg::cnt_w-1:0]  blck_count_sent;

  xfer_decode u_decode (
    .CLK       (CLK),
    .RST       (RST),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .rpt_valid (rpt_valid),
    .rpt       (rpt),
    .seg_valid (seg_valid),
    .seg       (seg),
    .busy      (busy)
  );

  page_sequencer u_seq (
    .CLK               (CLK),
    .RST               (RST),
    .seg_valid         (seg_valid),
    .seg               (seg),
    .mcu_page_addr     (mcu_page_addr),
    .mcu_request_align (mcu_request_align),
    .mcu_grant_align   (mcu_grant_align),
    .blck_start        (blck_start),
    .blck_count_req    (blck_count_req),
    .blck_section      (blck_section),
    .blck_issue        (blck_issue),
    .blck_working      (blck_working),
    .blck_count_sent   (blck_count_sent),
    .rpt_valid         (rpt_valid),
    .rpt               (rpt)
  );

  block_mover u_mover (
    .CLK             (CLK),
    .RST             (RST),
    .blck_issue      (blck_issue),
    .blck_start      (blck_start),
    .blck_count_req  (blck_count_req),
    .blck_section    (blck_section),
    .blck_working    (blck_working),
    .blck_count_sent (blck_count_sent),
    .word_valid      (word_valid),
    .word_addr       (word_addr),
    .word_section    (word_section)
  );

  xfer_result u_result (
    .CLK        (CLK),
    .RST        (RST),
    .rpt_valid  (rpt_valid),
    .rpt        (rpt),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .busy       (busy),
    .done_valid (done_valid),
    .done       (done)
  );

endmodule

// File: design/xfer_result.sv
`timescale 1ns/1ps

module xfer_result (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      rpt_valid,
  input  dram_xfer_pkg::seg_rpt_t   rpt,
  input  logic                      cmd_valid,
  input  dram_xfer_pkg::xfer_cmd_t  cmd,
  input  logic                      busy,
  output logic                      done_valid,
  output dram_xfer_pkg::xfer_done_t done
);

  logic [dram_xfer_pkg::addr_w-1:0] start_q;
  logic [dram_xfer_pkg::len_w-1:0]  total_q;
  logic [dram_xfer_pkg::len_w-1:0]  sum;

  assign sum = total_q + dram_xfer_pkg::len_w'(rpt.count);

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      done_valid <= 1'b0;
      total_q    <= '0;
    end
    else
    begin
      done_valid <= 1'b0;
      if (cmd_valid && !busy)  // command taken by decode
      begin
        start_q <= cmd.start;
        total_q <= '0;
        if (cmd.len == '0)
        begin
          done_valid     <= 1'b1;  // nothing to move
          done.total     <= '0;
          done.next_addr <= cmd.start;
        end
      end
      else if (rpt_valid)
      begin
        total_q <= sum;
        if (rpt.last)
        begin
          done_valid     <= 1'b1;
          done.total     <= sum;
          done.next_addr <= start_q + dram_xfer_pkg::addr_w'(sum);
        end
      end
    end
  end

endmodule

// File: design/block_mover.sv
`timescale 1ns/1ps

module block_mover (
  input  logic                            CLK,
  input  logic                            RST,
  input  logic                            blck_issue,
  input  logic [dram_xfer_pkg::addr_w-1:0] blck_start,
  input  logic [dram_xfer_pkg::cnt_w-1:0]  blck_count_req,
  input  logic [1:0]                      blck_section,
  output logic                            blck_working,
  output logic [dram_xfer_pkg::cnt_w-1:0]  blck_count_sent,
  output logic                            word_valid,
  output logic [dram_xfer_pkg::addr_w-1:0] word_addr,
  output logic [1:0]                      word_section
);

  logic [dram_xfer_pkg::addr_w-1:0] addr_q;
  logic [dram_xfer_pkg::cnt_w-1:0]  left_q;  // words still to send
  logic [1:0]                       section_q;

  // one word per working cycle
  assign word_valid   = blck_working;
  assign word_addr    = addr_q;
  assign word_section = section_q;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      blck_working    <= 1'b0;
      blck_count_sent <= '0;
      left_q          <= '0;
    end
    else if (blck_issue)
    begin
      addr_q          <= blck_start;
      section_q       <= blck_section;
      left_q          <= blck_count_req;
      blck_count_sent <= '0;
      blck_working    <= (blck_count_req != '0);
    end
    else if (blck_working)
    begin
      addr_q          <= addr_q + 1'b1;
      left_q          <= left_q - 1'b1;
      blck_count_sent <= blck_count_sent + 1'b1;
      if (left_q == dram_xfer_pkg::cnt_w'(1))
        blck_working <= 1'b0;  // this was the final word
    end
  end

endmodule

// File: design/page_sequencer.sv
`timescale 1ns/1ps

module page_sequencer (
  input  logic                                CLK,
  input  logic                                RST,
  input  logic                                seg_valid,
  input  dram_xfer_pkg::seg_t                 seg,
  // memory controller side
  output logic [dram_xfer_pkg::page_w-1:0]    mcu_page_addr,
  output logic                                mcu_request_align,
  input  logic                                mcu_grant_align,
  // block mover side
  output logic [dram_xfer_pkg::addr_w-1:0]    blck_start,
  output logic [dram_xfer_pkg::cnt_w-1:0]     blck_count_req,
  output logic [1:0]                          blck_section,
  output logic                                blck_issue,
  input  logic                                blck_working,
  input  logic [dram_xfer_pkg::cnt_w-1:0]     blck_count_sent,
  // segment report
  output logic                                rpt_valid,
  output dram_xfer_pkg::seg_rpt_t             rpt
);

  logic [dram_xfer_pkg::st_n-1:0] state;  // one-hot
  logic                           blck_working_prev;
  dram_xfer_pkg::seg_t            seg_q;  // segment held until the report

  logic go_issue;
  logic mover_done;

  // grant seen and mover free, issue in the next cycle
  assign go_issue = state[dram_xfer_pkg::st_wait_grant] && mcu_request_align &&
                    mcu_grant_align && !blck_working;

  // falling edge of working ends the segment
  assign mover_done = state[dram_xfer_pkg::st_wait_mover] &&
                      blck_working_prev && !blck_working;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state                        <= '0;
      state[dram_xfer_pkg::st_idle] <= 1'b1;
      blck_working_prev            <= 1'b0;
      mcu_request_align            <= 1'b0;
      blck_issue                   <= 1'b0;
      rpt_valid                    <= 1'b0;
    end
    else
    begin
      blck_working_prev <= blck_working;
      blck_issue        <= 1'b0;
      rpt_valid         <= 1'b0;

      if (state[dram_xfer_pkg::st_idle] && seg_valid)
      begin
        seg_q                         <= seg;
        state                         <= '0;
        state[dram_xfer_pkg::st_load] <= 1'b1;
      end

      if (state[dram_xfer_pkg::st_load])
      begin
        mcu_page_addr     <= seg_q.page;
        blck_start        <= {seg_q.page, seg_q.start};
        blck_count_req    <= seg_q.count;
        blck_section      <= seg_q.section;
        mcu_request_align <= 1'b1;  // ask the controller to align the page
        state                               <= '0;
        state[dram_xfer_pkg::st_wait_grant] <= 1'b1;
      end

      // a withdrawn grant just keeps us here
      if (go_issue)
      begin
        blck_issue                          <= 1'b1;
        state                               <= '0;
        state[dram_xfer_pkg::st_wait_mover] <= 1'b1;
      end

      if (mover_done)
      begin
        mcu_request_align             <= 1'b0;
        rpt_valid                     <= 1'b1;
        rpt.count                     <= blck_count_sent;
        rpt.last                      <= seg_q.last;
        state                         <= '0;
        state[dram_xfer_pkg::st_idle] <= 1'b1;
      end
    end
  end

endmodule

// File: design/xfer_decode.sv
`timescale 1ns/1ps

module xfer_decode (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     cmd_valid,
  input  dram_xfer_pkg::xfer_cmd_t cmd,
  input  logic                     rpt_valid,
  input  dram_xfer_pkg::seg_rpt_t  rpt,
  output logic                     seg_valid,
  output dram_xfer_pkg::seg_t      seg,
  output logic                     busy
);

  logic [dram_xfer_pkg::addr_w-1:0] next_addr;  // start of the next segment
  logic [dram_xfer_pkg::len_w-1:0]  remain;     // words not yet segmented
  logic [1:0]                       section_q;

  logic                             accept;
  logic                             advance;
  logic [dram_xfer_pkg::addr_w-1:0] src_addr;
  logic [dram_xfer_pkg::len_w-1:0]  src_len;
  logic [1:0]                       src_section;
  dram_xfer_pkg::seg_t              nxt_seg;

  // smallest of block length, room left in the page and remaining length
  function automatic dram_xfer_pkg::seg_t cut_seg(
    input logic [dram_xfer_pkg::addr_w-1:0] addr,
    input logic [dram_xfer_pkg::len_w-1:0]  left,
    input logic [1:0]                       section
  );
    logic [dram_xfer_pkg::page_bits:0] to_page;
    logic [dram_xfer_pkg::len_w-1:0]   n;
    dram_xfer_pkg::seg_t               s;
    to_page = {1'b1, {dram_xfer_pkg::page_bits{1'b0}}} -
              {1'b0, addr[dram_xfer_pkg::page_bits-1:0]};
    n = left;
    if (n > dram_xfer_pkg::len_w'(dram_xfer_pkg::block_len))
      n = dram_xfer_pkg::len_w'(dram_xfer_pkg::block_len);
    if (n > dram_xfer_pkg::len_w'(to_page))
      n = dram_xfer_pkg::len_w'(to_page);
    s.page    = addr[dram_xfer_pkg::addr_w-1:dram_xfer_pkg::page_bits];
    s.start   = addr[dram_xfer_pkg::page_bits-1:0];
    s.count   = dram_xfer_pkg::cnt_w'(n);
    s.section = section;
    s.last    = (left == n);
    return s;
  endfunction

  assign accept  = cmd_valid && !busy;
  assign advance = busy && rpt_valid && !rpt.last;  // more words to go

  always_comb
  begin
    src_addr    = accept ? cmd.start : next_addr;
    src_len     = accept ? cmd.len : remain;
    src_section = accept ? cmd.section : section_q;
    nxt_seg     = cut_seg(src_addr, src_len, src_section);
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      busy      <= 1'b0;
      seg_valid <= 1'b0;
    end
    else
    begin
      seg_valid <= 1'b0;
      if ((accept && cmd.len != '0) || advance)
      begin
        busy      <= 1'b1;
        seg_valid <= 1'b1;
        seg       <= nxt_seg;
        next_addr <= src_addr + dram_xfer_pkg::addr_w'(nxt_seg.count);
        remain    <= src_len - dram_xfer_pkg::len_w'(nxt_seg.count);
        section_q <= src_section;
      end
      if (busy && rpt_valid && rpt.last)
        busy <= 1'b0;  // transfer finished
    end
  end

endmodule

// File: design/dram_xfer_pkg.sv
package dram_xfer_pkg;

  // transfer geometry
  localparam int unsigned block_len = 24;  // largest segment in words
  localparam int unsigned page_bits = 12;  // 4096-word dram page
  localparam int unsigned addr_w    = 32;
  localparam int unsigned len_w     = 16;
  localparam int unsigned cnt_w     = 5;   // holds up to block_len
  localparam int unsigned page_w    = addr_w - page_bits;

  // page sequencer state bits, one-hot
  localparam int unsigned st_idle       = 0;
  localparam int unsigned st_load       = 1;
  localparam int unsigned st_wait_grant = 2;
  localparam int unsigned st_wait_mover = 3;
  localparam int unsigned st_n          = 4;

  typedef struct packed {
    logic [addr_w-1:0] start;  // first word address
    logic [len_w-1:0]  len;    // words to move
    logic [1:0]        section;
  } xfer_cmd_t;

  typedef struct packed {
    logic [page_w-1:0]    page;   // dram page address
    logic [page_bits-1:0] start;  // offset inside the page
    logic [cnt_w-1:0]     count;
    logic [1:0]           section;
    logic                 last;   // final segment of the transfer
  } seg_t;

  typedef struct packed {
    logic [cnt_w-1:0] count;  // words the mover sent
    logic             last;
  } seg_rpt_t;

  typedef struct packed {
    logic [len_w-1:0]  total;
    logic [addr_w-1:0] next_addr;  // first word after the transfer
  } xfer_done_t;

endpackage
